// File: verilog/proc_defs.svh
// processor core sizes and instruction encodings
// register file sizes, data width, operate format opcodes and function codes
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

`define ARF_SIZE	32		// architectural registers
`define PRF_SIZE	64		// physical registers
`define ROB_SIZE	16		// reorder buffer entries
`define XLEN		64		// datapath width
`define ZERO_REG	5'd31	// reads as zero, never renamed

// operate format opcodes
`define OP_INTA		6'h10	// integer arithmetic
`define OP_INTL		6'h11	// integer logical

// function codes under INTA
`define FN_ADDQ		7'h20
`define FN_SUBQ		7'h29
// function codes under INTL
`define FN_AND		7'h00
`define FN_BIS		7'h20	// bitwise or
`define FN_XOR		7'h40
`endif

// File: verilog/proc_pkg.sv
// processor core types
// the two views of an operate format word and the ALU operation codes
`default_nettype none

package proc_pkg;

	// register form, rb is the second source
	typedef struct packed {
		logic [5:0]	opcode;
		logic [4:0]	ra;
		logic [4:0]	rb;
		logic [2:0]	pad;		// should be zero
		logic		lit_flag;	// low in this form
		logic [6:0]	func;
		logic [4:0]	rc;			// destination
	} reg_view_t;

	// literal form, 8 bit literal replaces rb
	typedef struct packed {
		logic [5:0]	opcode;
		logic [4:0]	ra;
		logic [7:0]	literal;	// zero extended by ex
		logic		lit_flag;	// high in this form
		logic [6:0]	func;
		logic [4:0]	rc;
	} lit_view_t;

	typedef union packed {
		reg_view_t	reg_view;
		lit_view_t	lit_view;
	} alpha_inst_u;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

endpackage

`default_nettype wire

// File: verilog/decode_stage.sv
// decode stage
// reads the operate word through its register or literal view, maps opcode
// and function to an ALU operation and drops every other word
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module decode_stage (
	input  wire								clock,
	input  wire								reset,
	input  wire								inst_valid,		// word on inst is offered
	input  wire proc_pkg::alpha_inst_u		inst,
	input  wire								stall,			// hold the decoded word
	output logic							dec_valid,
	output logic [$clog2(`ARF_SIZE)-1:0]	dec_ra,
	output logic [$clog2(`ARF_SIZE)-1:0]	dec_rb,
	output logic [7:0]						dec_literal,
	output logic							dec_lit_flag,
	output logic [$clog2(`ARF_SIZE)-1:0]	dec_rc,
	output proc_pkg::alu_op_e				dec_op
);
	import proc_pkg::*;

	logic		op_known;	// opcode and function both recognized
	alu_op_e	op_next;

	always_comb begin
		op_known = 1'b1;
		op_next  = ALU_ADD;
		case (inst.reg_view.opcode)
			`OP_INTA: begin
				case (inst.reg_view.func)
					`FN_ADDQ:	op_next = ALU_ADD;
					`FN_SUBQ:	op_next = ALU_SUB;
					default:	op_known = 1'b0;
				endcase
			end
			`OP_INTL: begin
				case (inst.reg_view.func)
					`FN_AND:	op_next = ALU_AND;
					`FN_BIS:	op_next = ALU_OR;
					`FN_XOR:	op_next = ALU_XOR;
					default:	op_known = 1'b0;
				endcase
			end
			default:	op_known = 1'b0;	// memory, branch, etc. not kept here
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else if (!stall) begin
			dec_valid <= inst_valid && op_known;	// unknown words vanish here
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			dec_ra       <= inst.reg_view.ra;
			dec_lit_flag <= inst.reg_view.lit_flag;
			dec_rc       <= inst.reg_view.rc;
			dec_op       <= op_next;
			if (inst.reg_view.lit_flag) begin
				dec_literal <= inst.lit_view.literal;
				dec_rb      <= `ZERO_REG;	// no second register source
			end else begin
				dec_literal <= 8'd0;
				dec_rb      <= inst.reg_view.rb;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/rename_stage.sv
// rename stage
// maps architectural sources through the rename table, pops a free physical
// register for each real destination and takes back what the ROB retires;
// raises stall when the free list is empty or the ROB cannot take more
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module rename_stage (
	input  wire								clock,
	input  wire								reset,
	input  wire								dec_valid,
	input  wire [$clog2(`ARF_SIZE)-1:0]		dec_ra,
	input  wire [$clog2(`ARF_SIZE)-1:0]		dec_rb,
	input  wire								dec_lit_flag,
	input  wire [7:0]						dec_literal,
	input  wire [$clog2(`ARF_SIZE)-1:0]		dec_rc,
	input  wire proc_pkg::alu_op_e			dec_op,
	input  wire								rob_full,
	input  wire								free_valid,		// rob hands a register back
	input  wire [$clog2(`PRF_SIZE)-1:0]		free_prn,
	output logic							stall,
	output logic [$clog2(`PRF_SIZE)-1:0]	src_a_prn,		// to prf read ports
	output logic [$clog2(`PRF_SIZE)-1:0]	src_b_prn,
	output logic							ren_valid,
	output proc_pkg::alu_op_e				ren_op,
	output logic [7:0]						ren_literal,
	output logic							ren_lit_flag,
	output logic							ren_src_a_zero,	// source is r31
	output logic							ren_src_b_zero,
	output logic [$clog2(`PRF_SIZE)-1:0]	ren_prn,		// new destination
	output logic [$clog2(`ARF_SIZE)-1:0]	ren_arn,
	output logic [$clog2(`PRF_SIZE)-1:0]	old_prn,		// freed when this commits
	output logic							rob_alloc
);
	localparam int FL_DEPTH = `PRF_SIZE - `ARF_SIZE;	// most registers ever free

	logic [$clog2(`PRF_SIZE)-1:0]	rat_q [`ARF_SIZE];		// arch to phys map
	logic [$clog2(`PRF_SIZE)-1:0]	fl_q [FL_DEPTH];		// free list ring
	logic [$clog2(FL_DEPTH)-1:0]	fl_head;				// next to pop
	logic [$clog2(FL_DEPTH)-1:0]	fl_tail;				// next push slot
	logic [$clog2(FL_DEPTH):0]		fl_count;
	logic							take;					// decoded inst moves in
	logic							fl_pop;

	assign stall     = (fl_count == 0) || rob_full;
	assign take      = dec_valid && !stall;
	assign fl_pop    = take && (dec_rc != `ZERO_REG);	// r31 writes get no register
	assign rob_alloc = ren_valid;

	////////////////////////////////////////////////////////////////////////////
	// rename table and free list
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++) begin
				rat_q[i] <= ($clog2(`PRF_SIZE))'(i);	// identity map
			end
			for (int i = 0; i < FL_DEPTH; i++) begin
				fl_q[i] <= ($clog2(`PRF_SIZE))'(`ARF_SIZE + i);	// 32..63 free
			end
			fl_head   <= '0;
			fl_tail   <= '0;	// ring full, tail wrapped onto head
			fl_count  <= ($clog2(FL_DEPTH)+1)'(FL_DEPTH);
			ren_valid <= 1'b0;
		end else begin
			if (fl_pop) begin
				rat_q[dec_rc] <= fl_q[fl_head];
				fl_head       <= fl_head + 1'b1;
			end
			if (free_valid) begin
				fl_q[fl_tail] <= free_prn;
				fl_tail       <= fl_tail + 1'b1;
			end
			fl_count  <= fl_count + ($clog2(FL_DEPTH)+1)'(free_valid)
			             - ($clog2(FL_DEPTH)+1)'(fl_pop);
			ren_valid <= take;	// bubble while stalled
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// renamed instruction register
	always_ff @(posedge clock) begin
		if (take) begin
			src_a_prn      <= rat_q[dec_ra];	// old mapping, before own update
			src_b_prn      <= rat_q[dec_rb];
			ren_src_a_zero <= (dec_ra == `ZERO_REG);
			ren_src_b_zero <= (dec_rb == `ZERO_REG);
			ren_op         <= dec_op;
			ren_literal    <= dec_literal;
			ren_lit_flag   <= dec_lit_flag;
			ren_arn        <= dec_rc;
			old_prn        <= rat_q[dec_rc];
			ren_prn        <= fl_pop ? fl_q[fl_head] : rat_q[dec_rc];	// r31 stays on 31
		end
	end

	// the rob only hands back registers that rename once took out
	assert property (@(posedge clock) disable iff (reset)
		free_valid && !fl_pop |-> fl_count != FL_DEPTH)
		else $error("rename: push into a full free list");

endmodule

`default_nettype wire

// File: verilog/prf.sv
// physical register file
// holds every renamed value, forwards the writeback word to both source
// reads and gives the committed value on a separate read port
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module prf (
	input  wire								clock,
	input  wire								reset,
	input  wire [$clog2(`PRF_SIZE)-1:0]		src_a_prn,
	input  wire [$clog2(`PRF_SIZE)-1:0]		src_b_prn,
	input  wire								wb_valid,
	input  wire [$clog2(`PRF_SIZE)-1:0]		wb_prn,
	input  wire [`XLEN-1:0]					wb_value,
	input  wire [$clog2(`PRF_SIZE)-1:0]		commit_prn,		// head of rob
	output logic [`XLEN-1:0]				src_a_value,
	output logic [`XLEN-1:0]				src_b_value,
	output logic [`XLEN-1:0]				commit_value
);
	logic [`XLEN-1:0]	regs_q [`PRF_SIZE];
	logic				fwd_a;		// source a is being written now
	logic				fwd_b;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `PRF_SIZE; i++) begin
				regs_q[i] <= '0;	// architectural state starts at zero
			end
		end else if (wb_valid) begin
			regs_q[wb_prn] <= wb_value;
		end
	end

	// back to back dependency, the producer writes at the same edge
	assign fwd_a = wb_valid && (wb_prn == src_a_prn);
	assign fwd_b = wb_valid && (wb_prn == src_b_prn);

	assign src_a_value  = fwd_a ? wb_value : regs_q[src_a_prn];
	assign src_b_value  = fwd_b ? wb_value : regs_q[src_b_prn];
	assign commit_value = regs_q[commit_prn];	// done entries are already written

endmodule

`default_nettype wire

// File: verilog/ex_stage.sv
// execute stage
// selects operands, runs the single cycle ALU and registers the result
// for writeback to the register file and the ROB
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module ex_stage (
	input  wire								clock,
	input  wire								reset,
	input  wire								ren_valid,
	input  wire proc_pkg::alu_op_e			ren_op,
	input  wire [7:0]						ren_literal,
	input  wire								ren_lit_flag,
	input  wire								ren_src_a_zero,
	input  wire								ren_src_b_zero,
	input  wire [$clog2(`PRF_SIZE)-1:0]		ren_prn,
	input  wire [$clog2(`ROB_SIZE)-1:0]		ren_idx,		// rob entry of this inst
	input  wire [`XLEN-1:0]					src_a_value,
	input  wire [`XLEN-1:0]					src_b_value,
	output logic							wb_valid,
	output logic [$clog2(`PRF_SIZE)-1:0]	wb_prn,
	output logic [`XLEN-1:0]				wb_value,
	output logic [$clog2(`ROB_SIZE)-1:0]	wb_rob_idx
);
	import proc_pkg::*;

	logic [`XLEN-1:0]	opa;
	logic [`XLEN-1:0]	opb;
	logic [`XLEN-1:0]	result;

	assign opa = ren_src_a_zero ? '0 : src_a_value;	// r31 reads zero
	assign opb = ren_lit_flag   ? {{(`XLEN-8){1'b0}}, ren_literal}
	           : ren_src_b_zero ? '0 : src_b_value;

	always_comb begin
		case (ren_op)
			ALU_ADD:	result = opa + opb;
			ALU_SUB:	result = opa - opb;
			ALU_AND:	result = opa & opb;
			ALU_OR:		result = opa | opb;
			ALU_XOR:	result = opa ^ opb;
			default:	result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ren_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (ren_valid) begin
			wb_prn     <= ren_prn;
			wb_value   <= result;
			wb_rob_idx <= ren_idx;
		end
	end

endmodule

`default_nettype wire

// File: verilog/rob.sv
// reorder buffer
// circular buffer of renamed instructions, marked done on writeback and
// committed strictly in program order, one per cycle; a commit returns
// the previous mapping of its destination to the free list
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module rob (
	input  wire								clock,
	input  wire								reset,
	input  wire								rob_alloc,
	input  wire [$clog2(`ARF_SIZE)-1:0]		ren_arn,
	input  wire [$clog2(`PRF_SIZE)-1:0]		ren_prn,
	input  wire [$clog2(`PRF_SIZE)-1:0]		old_prn,
	input  wire								wb_valid,
	input  wire [$clog2(`ROB_SIZE)-1:0]		wb_rob_idx,
	output logic [$clog2(`ROB_SIZE)-1:0]	rob_tail,		// index the next alloc gets
	output logic							rob_full,
	output logic							free_valid,
	output logic [$clog2(`PRF_SIZE)-1:0]	free_prn,
	output logic [$clog2(`PRF_SIZE)-1:0]	commit_prn,
	output logic							commit_valid,
	output logic [$clog2(`ARF_SIZE)-1:0]	commit_arn,
	output logic							commit_wr_en
);
	logic [$clog2(`ARF_SIZE)-1:0]	arn_q [`ROB_SIZE];
	logic [$clog2(`PRF_SIZE)-1:0]	prn_q [`ROB_SIZE];
	logic [$clog2(`PRF_SIZE)-1:0]	old_q [`ROB_SIZE];
	logic [`ROB_SIZE-1:0]			done_q;
	logic [$clog2(`ROB_SIZE)-1:0]	head;
	logic [$clog2(`ROB_SIZE)-1:0]	tail;
	logic [$clog2(`ROB_SIZE):0]		count;
	logic [$clog2(`ROB_SIZE)-1:0]	wb_off;		// writeback distance from head

	assign rob_tail = tail;
	// one more inst may already sit in the rename register
	assign rob_full = (count == `ROB_SIZE) || ((count == `ROB_SIZE - 1) && rob_alloc);

	assign commit_valid = (count != 0) && done_q[head];
	assign commit_arn   = arn_q[head];
	assign commit_prn   = prn_q[head];
	assign commit_wr_en = (arn_q[head] != `ZERO_REG);
	assign free_valid   = commit_valid && commit_wr_en;	// r31 never held a register
	assign free_prn     = old_q[head];
	assign wb_off       = wb_rob_idx - head;

	always_ff @(posedge clock) begin
		if (reset) begin
			head   <= '0;
			tail   <= '0;
			count  <= '0;
			done_q <= '0;
		end else begin
			if (rob_alloc) begin
				done_q[tail] <= 1'b0;
				tail         <= tail + 1'b1;
			end
			if (wb_valid) begin
				done_q[wb_rob_idx] <= 1'b1;
			end
			if (commit_valid) begin
				head <= head + 1'b1;
			end
			count <= count + ($clog2(`ROB_SIZE)+1)'(rob_alloc)
			         - ($clog2(`ROB_SIZE)+1)'(commit_valid);
		end
	end

	always_ff @(posedge clock) begin
		if (rob_alloc) begin
			arn_q[tail] <= ren_arn;
			prn_q[tail] <= ren_prn;
			old_q[tail] <= old_prn;
		end
	end

	assert property (@(posedge clock) disable iff (reset) rob_alloc |-> count != `ROB_SIZE)
		else $error("rob: allocation while full");

	// ex may only finish an entry that is live and still pending
	assert property (@(posedge clock) disable iff (reset)
		wb_valid |-> ({1'b0, wb_off} < count) && !done_q[wb_rob_idx])
		else $error("rob: writeback to an empty entry");

endmodule

`default_nettype wire

// File: verilog/proc_top.sv
// renaming core top
// in order pipeline of decode, rename, execute and writeback around the
// physical register file and the reorder buffer
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module proc_top (
	input  wire								clock,
	input  wire								reset,
	input  wire								inst_valid,
	input  wire [31:0]						inst,
	output logic							stall,
	output logic							commit_valid,
	output logic [$clog2(`ARF_SIZE)-1:0]	commit_arn,
	output logic							commit_wr_en,
	output logic [`XLEN-1:0]				commit_value
);
	import proc_pkg::*;

	// decode to rename
	logic							dec_valid;
	logic [$clog2(`ARF_SIZE)-1:0]	dec_ra;
	logic [$clog2(`ARF_SIZE)-1:0]	dec_rb;
	logic [7:0]						dec_literal;
	logic							dec_lit_flag;
	logic [$clog2(`ARF_SIZE)-1:0]	dec_rc;
	alu_op_e						dec_op;
	// rename to prf, ex and rob
	logic [$clog2(`PRF_SIZE)-1:0]	src_a_prn;
	logic [$clog2(`PRF_SIZE)-1:0]	src_b_prn;
	logic							ren_valid;
	alu_op_e						ren_op;
	logic [7:0]						ren_literal;
	logic							ren_lit_flag;
	logic							ren_src_a_zero;
	logic							ren_src_b_zero;
	logic [$clog2(`PRF_SIZE)-1:0]	ren_prn;
	logic [$clog2(`ARF_SIZE)-1:0]	ren_arn;
	logic [$clog2(`PRF_SIZE)-1:0]	old_prn;
	logic							rob_alloc;
	// prf read data
	logic [`XLEN-1:0]				src_a_value;
	logic [`XLEN-1:0]				src_b_value;
	// writeback
	logic							wb_valid;
	logic [$clog2(`PRF_SIZE)-1:0]	wb_prn;
	logic [`XLEN-1:0]				wb_value;
	logic [$clog2(`ROB_SIZE)-1:0]	wb_rob_idx;
	// rob feedback
	logic [$clog2(`ROB_SIZE)-1:0]	rob_tail;
	logic							rob_full;
	logic							free_valid;
	logic [$clog2(`PRF_SIZE)-1:0]	free_prn;
	logic [$clog2(`PRF_SIZE)-1:0]	commit_prn;

	////////////////////////////////////////////////////////////////////////////
	// front end
	decode_stage id (
		.clock(clock), .reset(reset),
		.inst_valid(inst_valid), .inst(inst),
		.stall(stall),									// held together with rename
		.dec_valid(dec_valid), .dec_ra(dec_ra), .dec_rb(dec_rb),
		.dec_literal(dec_literal), .dec_lit_flag(dec_lit_flag),
		.dec_rc(dec_rc), .dec_op(dec_op)
	);

	rename_stage rat (
		.clock(clock), .reset(reset),
		.dec_valid(dec_valid), .dec_ra(dec_ra), .dec_rb(dec_rb),
		.dec_lit_flag(dec_lit_flag), .dec_literal(dec_literal),
		.dec_rc(dec_rc), .dec_op(dec_op),
		.rob_full(rob_full),
		.free_valid(free_valid), .free_prn(free_prn),	// registers coming back on commit
		.stall(stall),
		.src_a_prn(src_a_prn), .src_b_prn(src_b_prn),
		.ren_valid(ren_valid), .ren_op(ren_op),
		.ren_literal(ren_literal), .ren_lit_flag(ren_lit_flag),
		.ren_src_a_zero(ren_src_a_zero), .ren_src_b_zero(ren_src_b_zero),
		.ren_prn(ren_prn), .ren_arn(ren_arn), .old_prn(old_prn),
		.rob_alloc(rob_alloc)
	);

	////////////////////////////////////////////////////////////////////////////
	// back end
	prf prf1 (
		.clock(clock), .reset(reset),
		.src_a_prn(src_a_prn), .src_b_prn(src_b_prn),
		.wb_valid(wb_valid), .wb_prn(wb_prn), .wb_value(wb_value),
		.commit_prn(commit_prn),
		.src_a_value(src_a_value), .src_b_value(src_b_value),
		.commit_value(commit_value)
	);

	ex_stage ex (
		.clock(clock), .reset(reset),
		.ren_valid(ren_valid), .ren_op(ren_op),
		.ren_literal(ren_literal), .ren_lit_flag(ren_lit_flag),
		.ren_src_a_zero(ren_src_a_zero), .ren_src_b_zero(ren_src_b_zero),
		.ren_prn(ren_prn),
		.ren_idx(rob_tail),								// entry allocated this cycle
		.src_a_value(src_a_value), .src_b_value(src_b_value),
		.wb_valid(wb_valid), .wb_prn(wb_prn), .wb_value(wb_value),
		.wb_rob_idx(wb_rob_idx)
	);

	rob rob1 (
		.clock(clock), .reset(reset),
		.rob_alloc(rob_alloc), .ren_arn(ren_arn),
		.ren_prn(ren_prn), .old_prn(old_prn),
		.wb_valid(wb_valid), .wb_rob_idx(wb_rob_idx),
		.rob_tail(rob_tail), .rob_full(rob_full),
		.free_valid(free_valid), .free_prn(free_prn),
		.commit_prn(commit_prn),
		.commit_valid(commit_valid), .commit_arn(commit_arn),
		.commit_wr_en(commit_wr_en)
	);

endmodule

`default_nettype wire

// File: tb/commit_checker.sv
// commit checker for the renaming core
// keeps an architectural model of the 32 integer registers, queues the
// expected destination and value of every accepted word in program order
// and compares them with each commit
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module commit_checker (
	input  wire					clock,
	input  wire					reset,
	input  wire					inst_valid,
	input  wire [31:0]			inst,
	input  wire					stall,
	input  wire					commit_valid,
	input  wire [4:0]			commit_arn,
	input  wire					commit_wr_en,
	input  wire [`XLEN-1:0]		commit_value,
	output int					checks,
	output int					errors,
	output int					pending,		// queue depth
	output int					committed
);
	logic [`XLEN-1:0]	arch [`ARF_SIZE];		// r31 stays zero
	logic [4:0]			exp_arn_q [$];
	logic [`XLEN-1:0]	exp_val_q [$];

	function automatic logic known_op(input logic [5:0] opc, input logic [6:0] fn);
		if (opc == `OP_INTA)
			return (fn == `FN_ADDQ) || (fn == `FN_SUBQ);
		if (opc == `OP_INTL)
			return (fn == `FN_AND) || (fn == `FN_BIS) || (fn == `FN_XOR);
		return 1'b0;
	endfunction

	function automatic logic [`XLEN-1:0] model_result(input logic [5:0] opc,
			input logic [6:0] fn, input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		if (opc == `OP_INTA)
			return (fn == `FN_ADDQ) ? a + b : a - b;
		case (fn)
			`FN_AND:	return a & b;
			`FN_BIS:	return a | b;
			default:	return a ^ b;
		endcase
	endfunction

	task automatic compare(input string sig, input logic [`XLEN-1:0] got,
			input logic [`XLEN-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %0h expected %0h", $time, sig, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// commit side, oldest expected entry against the DUT outputs
	task automatic check_commit();
		logic [4:0]			arn;
		logic [`XLEN-1:0]	val;
		committed++;
		if (exp_arn_q.size() == 0) begin
			errors++;
			$display("error at %0t: commit of r%0d with no instruction outstanding",
			         $time, commit_arn);
			return;
		end
		arn = exp_arn_q.pop_front();
		val = exp_val_q.pop_front();
		compare("commit_arn", `XLEN'(commit_arn), `XLEN'(arn));
		compare("commit_wr_en", `XLEN'(commit_wr_en), `XLEN'(arn != `ZERO_REG));
		if (arn != `ZERO_REG)
			compare("commit_value", commit_value, val);	// r31 value is don't care
	endtask

	// accept side, decode the word the way the operate format defines it
	task automatic take_inst(input logic [31:0] w);
		logic [5:0]			opc;
		logic [6:0]			fn;
		logic [4:0]			rc;
		logic [`XLEN-1:0]	a;
		logic [`XLEN-1:0]	b;
		logic [`XLEN-1:0]	r;
		opc = w[31:26];
		fn  = w[11:5];
		rc  = w[4:0];
		if (!known_op(opc, fn))
			return;								// dropped at decode
		a = arch[w[25:21]];
		b = w[12] ? {{(`XLEN-8){1'b0}}, w[20:13]} : arch[w[20:16]];
		r = model_result(opc, fn, a, b);
		if (rc != `ZERO_REG)
			arch[rc] = r;
		exp_arn_q.push_back(rc);
		exp_val_q.push_back(r);
	endtask

	// sample mid cycle, everything here comes from DUT registers
	always @(negedge clock) begin
		if (reset) begin
			for (int i = 0; i < `ARF_SIZE; i++)
				arch[i] = '0;
			exp_arn_q.delete();
			exp_val_q.delete();
			checks    = 0;
			errors    = 0;
			committed = 0;
		end else begin
			// a full rob or an empty free list needs this many in flight
			if (stall && exp_arn_q.size() < `ROB_SIZE - 1) begin
				errors++;
				$display("error at %0t: stall high with only %0d instructions in flight",
				         $time, exp_arn_q.size());
			end
			if (commit_valid)
				check_commit();
			if (inst_valid && !stall)		// taken at the next rising edge
				take_inst(inst);
		end
		pending = exp_arn_q.size();
	end

endmodule

`default_nettype wire

// File: tb/proc_tb.sv
// testbench top for the renaming core
// drives random operate words from a fixed seed through six tests, waits for
// the reorder buffer to drain after each one and reports per test results
`timescale 1ns/1ps
`default_nettype none
`include "proc_defs.svh"

module proc_tb;
	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 1;		// inputs change just after the edge
	localparam int RESET_CYCLES = 3;
	localparam int N_PRELOAD    = 8;		// literal loads ahead of test 1
	localparam int N_BASIC      = 40;		// words per ordinary test
	localparam int N_BURST      = 64;
	localparam int N_TOTAL      = N_PRELOAD + 5 * N_BASIC + N_BURST;
	localparam int TIMEOUT      = 20 * N_TOTAL;
	localparam int SETTLE       = 6;		// commit comes 4 cycles after accept at the earliest

	logic				clock = 1'b0;
	logic				reset;
	logic				inst_valid;
	logic [31:0]		inst;
	wire				stall;
	wire				commit_valid;
	wire [4:0]			commit_arn;
	wire				commit_wr_en;
	wire [`XLEN-1:0]	commit_value;
	int					checks;
	int					errors;
	int					pending;			// accepted but not yet committed
	int					committed;
	integer				seed = 32'ha3b9;
	int					cycles = 0;
	int					stall_cycles;
	int					failed_tests = 0;
	int					tb_errors = 0;		// count and reset faults seen here
	int					err_mark;
	int					chk_mark;
	int					commit_mark;

	always #(CLK_PERIOD / 2) clock = ~clock;

	proc_top dut_i (
		.clock(clock), .reset(reset),
		.inst_valid(inst_valid), .inst(inst),
		.stall(stall),
		.commit_valid(commit_valid), .commit_arn(commit_arn),
		.commit_wr_en(commit_wr_en), .commit_value(commit_value)
	);

	commit_checker chk_i (
		.clock(clock), .reset(reset),
		.inst_valid(inst_valid), .inst(inst), .stall(stall),
		.commit_valid(commit_valid), .commit_arn(commit_arn),
		.commit_wr_en(commit_wr_en), .commit_value(commit_value),
		.checks(checks), .errors(errors), .pending(pending),
		.committed(committed)
	);

	// run limit
	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT) begin
			$display("timeout: the core did not drain within %0d cycles", TIMEOUT);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// word building and random helpers
	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return int'($unsigned(r) % n);
	endfunction

	function automatic logic [4:0] rand_reg();	// never r31
		return 5'(rand_below(31));
	endfunction

	// {opcode, func} for kind 0..4 = addq, subq, and, bis, xor
	function automatic logic [12:0] op_code(input int kind);
		case (kind)
			0:			return {`OP_INTA, `FN_ADDQ};
			1:			return {`OP_INTA, `FN_SUBQ};
			2:			return {`OP_INTL, `FN_AND};
			3:			return {`OP_INTL, `FN_BIS};
			default:	return {`OP_INTL, `FN_XOR};
		endcase
	endfunction

	function automatic logic [31:0] reg_word(input logic [12:0] op, input logic [4:0] ra,
			input logic [4:0] rb, input logic [4:0] rc);
		return {op[12:7], ra, rb, 3'b000, 1'b0, op[6:0], rc};
	endfunction

	function automatic logic [31:0] lit_word(input logic [12:0] op, input logic [4:0] ra,
			input logic [7:0] lit, input logic [4:0] rc);
		return {op[12:7], ra, lit, 1'b1, op[6:0], rc};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// drive tasks, all entered and left just after a rising edge
	task automatic send_word(input logic [31:0] word);
		logic held;
		inst_valid = 1'b1;
		inst       = word;
		held       = 1'b1;
		while (held) begin
			@(negedge clock);
			held = stall;			// stall only moves on the edge
			if (held)
				stall_cycles++;
			@(posedge clock);
			#DRIVE_DELAY;
		end
	endtask

	task automatic idle_cycle();
		inst_valid = 1'b0;
		inst       = $random(seed);	// junk that must be ignored
		@(posedge clock);
		#DRIVE_DELAY;
	endtask

	task automatic maybe_gap();
		if (rand_below(4) == 0)
			idle_cycle();
	endtask

	task automatic drain();
		inst_valid = 1'b0;
		while (pending != 0) begin
			@(posedge clock);
			#DRIVE_DELAY;
		end
		repeat (SETTLE) @(posedge clock);	// room for a stray commit to show
		#DRIVE_DELAY;
	endtask

	task automatic begin_test();
		err_mark     = errors + tb_errors;
		chk_mark     = checks;
		commit_mark  = committed;
		stall_cycles = 0;
	endtask

	task automatic end_test(input int num, input string name, input int n_known);
		int errs;
		drain();
		if (committed - commit_mark != n_known) begin
			tb_errors++;
			$display("test %0d: %0d instructions committed where %0d were sent",
			         num, committed - commit_mark, n_known);
		end
		errs = errors + tb_errors - err_mark;
		if (errs == 0) begin
			$display("test %0d %s: ok, %0d checks, %0d stall cycles",
			         num, name, checks - chk_mark, stall_cycles);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors in %0d checks",
			         num, name, errs, checks - chk_mark);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	task automatic test_add_sub();
		begin_test();
		for (int i = 0; i < N_PRELOAD; i++)		// give registers nonzero values
			send_word(lit_word(op_code(0), `ZERO_REG, 8'(rand_below(256)), rand_reg()));
		for (int i = 0; i < N_BASIC; i++) begin
			send_word(reg_word(op_code(rand_below(2)), rand_reg(), rand_reg(), rand_reg()));
			maybe_gap();
		end
		end_test(1, "register add and subtract", N_PRELOAD + N_BASIC);
	endtask

	task automatic test_literal();
		begin_test();
		for (int i = 0; i < N_BASIC; i++) begin
			send_word(lit_word(op_code(rand_below(5)), rand_reg(), 8'(rand_below(256)),
			                   rand_reg()));
			maybe_gap();
		end
		end_test(2, "literal forms", N_BASIC);
	endtask

	task automatic test_logical();
		begin_test();
		for (int i = 0; i < N_BASIC; i++) begin
			send_word(reg_word(op_code(2 + rand_below(3)), rand_reg(), rand_reg(),
			                   rand_reg()));
			maybe_gap();
		end
		end_test(3, "bitwise and, or, xor", N_BASIC);
	endtask

	task automatic test_chain();
		logic [4:0] prev;
		logic [4:0] rb;
		logic [4:0] rc;
		begin_test();
		prev = rand_reg();
		for (int i = 0; i < N_BASIC; i++) begin
			rb = (rand_below(2) == 0) ? prev : rand_reg();
			rc = rand_reg();
			send_word(reg_word(op_code(rand_below(5)), prev, rb, rc));	// no gaps
			prev = rc;
		end
		end_test(4, "dependent chains", N_BASIC);
	endtask

	task automatic test_zero_reg();
		int			n_known;
		logic [5:0]	opc;
		logic [6:0]	fn;
		logic [12:0]	op;
		n_known = 0;
		begin_test();
		for (int i = 0; i < N_BASIC; i++) begin
			op = op_code(rand_below(5));
			case (rand_below(4))
				0: send_word(reg_word(op, rand_reg(), rand_reg(), `ZERO_REG));
				1: send_word(reg_word(op, `ZERO_REG, rand_reg(), rand_reg()));
				2: begin
					opc = 6'(rand_below(64));
					fn  = 7'(rand_below(128));
					if (opc == `OP_INTA || opc == `OP_INTL)
						fn = 7'h7f;				// no such function under either
					send_word(reg_word({opc, fn}, rand_reg(), rand_reg(), rand_reg()));
				end
				default: send_word(reg_word(op, rand_reg(), `ZERO_REG, rand_reg()));
			endcase
			if (inst[31:26] == `OP_INTA || inst[31:26] == `OP_INTL)
				if (inst[11:5] != 7'h7f)
					n_known++;
			maybe_gap();
		end
		end_test(5, "zero register and unknown words", n_known);
	endtask

	task automatic test_burst();
		begin_test();
		for (int i = 0; i < N_BURST; i++) begin	// inst_valid stays high
			if (rand_below(2) == 0)
				send_word(reg_word(op_code(rand_below(5)), 5'(rand_below(32)),
				                   5'(rand_below(32)), 5'(rand_below(32))));
			else
				send_word(lit_word(op_code(rand_below(5)), 5'(rand_below(32)),
				                   8'(rand_below(256)), 5'(rand_below(32))));
		end
		end_test(6, "burst under stall", N_BURST);
	endtask

	initial begin
		reset      = 1'b1;
		inst_valid = 1'b0;
		inst       = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY;
		reset = 1'b0;
		if (stall !== 1'b0 || commit_valid !== 1'b0) begin
			tb_errors++;
			$display("after reset stall or commit_valid is not low");
		end
		test_add_sub();
		test_literal();
		test_logical();
		test_chain();
		test_zero_reg();
		test_burst();
		$display("summary: %0d of 6 tests ok, %0d checks, %0d errors",
		         6 - failed_tests, checks, errors + tb_errors);
		if (failed_tests == 0 && errors == 0 && tb_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+verilog
verilog/proc_pkg.sv
verilog/decode_stage.sv
verilog/rename_stage.sv
verilog/prf.sv
verilog/ex_stage.sv
verilog/rob.sv
verilog/proc_top.sv
tb/commit_checker.sv
tb/proc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= proc_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= all tests passed
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
